// File: tb/tb_fetch_top.sv
module tb_fetch_top import fetch_pkg::*; ();

  localparam int N_DELIV  = 16;                  // Deliveries walked and checked
  localparam int WDOG_CYC = N_DELIV * 20 + 200;  // Watchdog limit in clock periods

  logic                  clk_i = 1'b0;
  logic                  rstn_i;
  logic                  run_i;
  logic                  ready_i;
  logic                  load_en_i;
  logic [ROM_AW-1:0]     load_addr_i;
  logic [DATA_WIDTH-1:0] load_data_i;
  logic                  valid_o;
  logic [DATA_WIDTH-1:0] instr_o;
  logic [DATA_WIDTH-1:0] pc_o;
  logic [DATA_WIDTH-1:0] imm_o;
  opcode_e               opcode_o;
  logic [4:0]            rd_o;
  logic [15:0]           issue_count_o;

  // Program image and expected decode, one slot per ROM word
  logic [DATA_WIDTH-1:0] rom_img  [ROM_DEPTH];
  opcode_e               exp_opc  [ROM_DEPTH];
  logic [4:0]            exp_rd   [ROM_DEPTH];
  logic [DATA_WIDTH-1:0] exp_imm  [ROM_DEPTH];
  bit                    imm_chk  [ROM_DEPTH];  // Format carries an immediate
  bit                    in_table [ROM_DEPTH];
  logic [DATA_WIDTH-1:0] exp_pc   [N_DELIV];    // Architectural stream
  int                    exp_idx  [N_DELIV];

  int     word_errs  = 0;
  int     field_errs = 0;
  int     ctrl_errs  = 0;
  int     n_deliv    = 0;   // Transfers seen at the output
  integer seed       = 32'h46b0;

  always #20 clk_i = ~clk_i;  // 40 unit period

  fetch_top dut_i (.*);

  //////////////////////////////
  // Compare tasks
  //////////////////////////////
  task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] exp_v,
                            input logic [DATA_WIDTH-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("[FAIL] %s: expected 0x%h, got 0x%h", name, exp_v, act_v);
      word_errs++;
    end
  endtask

  task automatic check_opcode(input string name, input opcode_e exp_v, input opcode_e act_v);
    if (act_v !== exp_v) begin
      $display("[FAIL] %s: expected 0x%h, got 0x%h", name, exp_v, act_v);
      field_errs++;
    end
  endtask

  task automatic check_rd(input string name, input logic [4:0] exp_v, input logic [4:0] act_v);
    if (act_v !== exp_v) begin
      $display("[FAIL] %s: expected 0x%h, got 0x%h", name, exp_v, act_v);
      field_errs++;
    end
  endtask

  task automatic check_count(input string name, input logic [15:0] exp_v,
                             input logic [15:0] act_v);
    if (act_v !== exp_v) begin
      $display("[FAIL] %s: expected 0x%h, got 0x%h", name, exp_v, act_v);
      ctrl_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("[FAIL] %s: expected 0x%h, got 0x%h", name, exp_v, act_v);
      ctrl_errs++;
    end
  endtask

  task automatic report_counts();
    $display("Errors: %0d word, %0d field, %0d control, after %0d of %0d deliveries",
             word_errs, field_errs, ctrl_errs, n_deliv, N_DELIV);
  endtask

  //////////////////////////////
  // Program table
  //////////////////////////////
  task automatic put_word(input int addr, input logic [DATA_WIDTH-1:0] instr,
                          input opcode_e opc, input logic [4:0] rd,
                          input logic [DATA_WIDTH-1:0] imm, input bit chk);
    rom_img[addr/4]  = instr;
    exp_opc[addr/4]  = opc;
    exp_rd[addr/4]   = rd;
    exp_imm[addr/4]  = imm;
    imm_chk[addr/4]  = chk;
    in_table[addr/4] = 1'b1;
  endtask

  task automatic fill_program();
    for (int i = 0; i < ROM_DEPTH; i++) begin
      rom_img[i] = (32'(i) << 22) | NOP_INSTR;  // addi x0,x0,<byte address>
    end
    //       addr instr          opcode      rd imm            imm applies
    put_word(0,  32'h0050_0093, OPC_OP_IMM, 1, 32'h0000_0005, 1'b1);  // addi x1,x0,5
    put_word(4,  32'h1234_5137, OPC_LUI,    2, 32'h1234_5000, 1'b1);  // lui x2,0x12345
    put_word(8,  32'h0180_006F, OPC_JAL,    0, 32'h0000_0018, 1'b1);  // Forward to 32
    put_word(12, 32'hFFF0_0293, OPC_OP_IMM, 5, 32'hFFFF_FFFF, 1'b1);  // Wrong path
    put_word(16, 32'hFFF0_0313, OPC_OP_IMM, 6, 32'hFFFF_FFFF, 1'b1);  // Wrong path
    put_word(20, 32'h0080_A183, OPC_LOAD,   3, 32'h0000_0008, 1'b1);  // lw x3,8(x1), loop head
    put_word(24, 32'h0011_2223, OPC_STORE,  0, 32'h0000_0004, 1'b1);  // sw x1,4(x2)
    put_word(28, 32'h0140_02EF, OPC_JAL,    5, 32'h0000_0014, 1'b1);  // Forward to 48
    put_word(32, 32'h8000_8393, OPC_OP_IMM, 7, 32'hFFFF_F800, 1'b1);  // addi x7,x1,-2048
    put_word(36, 32'hFE31_2C23, OPC_STORE,  0, 32'hFFFF_FFF8, 1'b1);  // sw x3,-8(x2)
    put_word(40, 32'hFEDF_F0EF, OPC_JAL,    1, 32'hFFFF_FFEC, 1'b1);  // Back to 20
    put_word(44, 32'hDEAD_C0B7, OPC_LUI,    1, 32'hDEAD_C000, 1'b1);  // Wrong path
    put_word(48, 32'h0020_84B3, OPC_OP,     9, 32'h0000_0000, 1'b0);  // add x9,x1,x2
    put_word(52, 32'h0000_006F, OPC_JAL,    0, 32'h0000_0000, 1'b1);  // End, jump to self
  endtask

  // Walk the program in order, taking every JAL
  task automatic build_expected();
    logic [DATA_WIDTH-1:0] pc;
    int                    idx;
    pc = BOOT_ADDR;
    for (int k = 0; k < N_DELIV; k++) begin
      idx        = pc[ROM_AW+1:2];
      exp_pc[k]  = pc;
      exp_idx[k] = idx;
      if (!in_table[idx]) begin
        $display("Expected stream ran off the program table at pc 0x%h", pc);
        ctrl_errs++;
      end
      if (exp_opc[idx] == OPC_JAL) begin
        pc = pc + exp_imm[idx];  // Target = pc + J-immediate
      end else begin
        pc = pc + PC_STEP;
      end
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    logic [DATA_WIDTH-1:0] held_instr;
    logic [DATA_WIDTH-1:0] held_pc;
    logic [DATA_WIDTH-1:0] held_imm;
    opcode_e               held_opc;
    logic [4:0]            held_rd;
    logic                  held;
    logic [31:0]           rnd;
    int                    k;
    rstn_i      <= 1'b0;
    run_i       <= 1'b0;
    ready_i     <= 1'b0;
    load_en_i   <= 1'b0;
    load_addr_i <= '0;
    load_data_i <= '0;
    fill_program();
    build_expected();
    repeat (5) @(posedge clk_i);
    rstn_i <= 1'b1;
    // Load while halted, output must stay idle
    for (int i = 0; i < ROM_DEPTH; i++) begin
      @(posedge clk_i);
      load_en_i   <= 1'b1;
      load_addr_i <= ROM_AW'(i);
      load_data_i <= rom_img[i];
      @(negedge clk_i);
      check_flag("valid_o", 1'b0, valid_o);
      check_count("issue_count_o", 16'd0, issue_count_o);
    end
    @(posedge clk_i);
    load_en_i <= 1'b0;
    run_i     <= 1'b1;
    held      = 1'b0;
    while (n_deliv < N_DELIV) begin
      @(negedge clk_i);  // Outputs and ready_i settled here
      if (held) begin  // Stalled last cycle, nothing may move
        check_flag("valid_o (held)", 1'b1, valid_o);
        check_word("instr_o (held)", held_instr, instr_o);
        check_word("pc_o (held)", held_pc, pc_o);
        check_word("imm_o (held)", held_imm, imm_o);
        check_opcode("opcode_o (held)", held_opc, opcode_o);
        check_rd("rd_o (held)", held_rd, rd_o);
      end
      held       = valid_o & ~ready_i;
      held_instr = instr_o;
      held_pc    = pc_o;
      held_imm   = imm_o;
      held_opc   = opcode_o;
      held_rd    = rd_o;
      if (valid_o === 1'b1 && ready_i === 1'b1) begin  // Transfer on the coming edge
        k = exp_idx[n_deliv];
        check_word("pc_o", exp_pc[n_deliv], pc_o);
        check_word("instr_o", rom_img[k], instr_o);
        check_opcode("opcode_o", exp_opc[k], opcode_o);
        check_rd("rd_o", exp_rd[k], rd_o);
        if (imm_chk[k]) begin
          check_word("imm_o", exp_imm[k], imm_o);
        end
        n_deliv++;
      end
      @(posedge clk_i);
      rnd = $random(seed);
      ready_i <= (rnd[7:0] < 8'd179);  // High about 70% of cycles
    end
    @(negedge clk_i);
    check_count("issue_count_o", 16'(n_deliv), issue_count_o);
    report_counts();
    if (word_errs + field_errs + ctrl_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WDOG_CYC) @(posedge clk_i);
    $display("Run timed out after %0d clock cycles without all deliveries", WDOG_CYC);
    report_counts();
    $display("Simulation FAILED");
    $finish;
  end

endmodule : tb_fetch_top

// File: verilog.f
verilog/fetch_pkg.sv
verilog/pipe_if.sv
verilog/instr_rom.sv
verilog/instr_fetch.sv
verilog/instr_decode.sv
verilog/dec_out_stage.sv
verilog/fetch_top.sv
tb/tb_fetch_top.sv

// File: verilog/dec_out_stage.sv
module dec_out_stage import fetch_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  dec_if.out                    d,

  // Downstream valid/ready
  output logic                  valid_o,
  input  logic                  ready_i,
  output logic [DATA_WIDTH-1:0] instr_o,
  output logic [DATA_WIDTH-1:0] pc_o,
  output logic [DATA_WIDTH-1:0] imm_o,
  output opcode_e               opcode_o,
  output logic [4:0]            rd_o,
  output logic [15:0]           issue_count_o  // Transfers seen at the output
);

  logic full_q;  // Register holds an item
  logic load;

  //////////////////////////////
  // Handshake
  //////////////////////////////
  // Space when empty or when the held item leaves this cycle
  assign d.ready = ~full_q | ready_i;
  assign load    = d.valid & d.ready;
  assign valid_o = full_q;

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      full_q <= 1'b0;
    end else if (d.ready) begin
      full_q <= d.valid;  // Refill or drain to empty
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (load) begin
      instr_o  <= d.instr;
      pc_o     <= d.pc;
      imm_o    <= d.imm;
      opcode_o <= d.opcode;
      rd_o     <= d.rd;
    end
  end

  //////////////////////////////
  // Issue counter
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      issue_count_o <= '0;
    end else if (full_q & ready_i) begin
      issue_count_o <= issue_count_o + 16'd1;  // Wraps at 64k
    end
  end

endmodule : dec_out_stage

// File: verilog/fetch_pkg.sv
package fetch_pkg;

  //////////////////////////////
  // Widths and sizes
  //////////////////////////////
  localparam int DATA_WIDTH   = 32;                 // Instruction and address width
  localparam int ROM_DEPTH    = 64;                 // 32-bit words in the instruction ROM
  localparam int ROM_AW       = $clog2(ROM_DEPTH);  // ROM word index width
  localparam int FETCH_STAGES = 3;                  // Depth of the fetch PC shift register

  //////////////////////////////
  // Fixed values
  //////////////////////////////
  // First fetch address after reset
  localparam logic [DATA_WIDTH-1:0] BOOT_ADDR = 32'h0000_0000;

  // addi x0,x0,0
  localparam logic [DATA_WIDTH-1:0] NOP_INSTR = 32'h0000_0013;

  localparam logic [DATA_WIDTH-1:0] PC_STEP   = 32'd4;  // Bytes per instruction

  //////////////////////////////
  // RV32I major opcodes
  //////////////////////////////
  // Enum values are the raw instr[6:0] patterns
  typedef enum logic [6:0] {
    OPC_LUI     = 7'b0110111,  // U-type
    OPC_AUIPC   = 7'b0010111,  // U-type
    OPC_JAL     = 7'b1101111,  // J-type
    OPC_JALR    = 7'b1100111,  // I-type
    OPC_BRANCH  = 7'b1100011,  // B-type
    OPC_LOAD    = 7'b0000011,  // I-type
    OPC_STORE   = 7'b0100011,  // S-type
    OPC_OP_IMM  = 7'b0010011,  // I-type
    OPC_OP      = 7'b0110011,  // R-type, no immediate
    OPC_SYSTEM  = 7'b1110011,  // I-type
    OPC_ILLEGAL = 7'b0000000   // Any pattern not listed above
  } opcode_e;

endpackage : fetch_pkg

// File: verilog/fetch_top.sv
module fetch_top import fetch_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  logic                  run_i,        // Lets fetch leave BOOT_ADDR
  input  logic                  ready_i,      // Downstream can take an instruction

  // ROM load port
  input  logic                  load_en_i,
  input  logic [ROM_AW-1:0]     load_addr_i,
  input  logic [DATA_WIDTH-1:0] load_data_i,

  // Decoded instruction stream
  output logic                  valid_o,
  output logic [DATA_WIDTH-1:0] instr_o,
  output logic [DATA_WIDTH-1:0] pc_o,
  output logic [DATA_WIDTH-1:0] imm_o,
  output opcode_e               opcode_o,
  output logic [4:0]            rd_o,
  output logic [15:0]           issue_count_o
);

  logic [DATA_WIDTH-1:0] rom_addr;  // Byte address from fetch
  logic [DATA_WIDTH-1:0] rom_data;  // Word one cycle later

  fetch_if fetch_bus ();
  dec_if   dec_bus ();

  instr_rom u_rom (
    .clk_i     (clk_i),
    .wr_en_i   (load_en_i),
    .wr_addr_i (load_addr_i),
    .wr_data_i (load_data_i),
    .rd_addr_i (rom_addr),
    .rd_data_o (rom_data)
  );

  instr_fetch u_fetch (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .run_i      (run_i),
    .rom_addr_o (rom_addr),
    .rom_data_i (rom_data),
    .f          (fetch_bus.fetch)
  );

  // Classifies, redirects on JAL and drops the wrong path
  instr_decode u_decode (
    .clk_i  (clk_i),
    .rstn_i (rstn_i),
    .f      (fetch_bus.decode),
    .d      (dec_bus.decode)
  );

  dec_out_stage u_out (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .d             (dec_bus.out),
    .valid_o       (valid_o),
    .ready_i       (ready_i),
    .instr_o       (instr_o),
    .pc_o          (pc_o),
    .imm_o         (imm_o),
    .opcode_o      (opcode_o),
    .rd_o          (rd_o),
    .issue_count_o (issue_count_o)
  );

endmodule : fetch_top

// File: verilog/instr_decode.sv
module instr_decode import fetch_pkg::*; (
  input  logic    clk_i,
  input  logic    rstn_i,
  fetch_if.decode f,
  dec_if.decode   d
);

  opcode_e               opcode;
  logic [DATA_WIDTH-1:0] imm_i;
  logic [DATA_WIDTH-1:0] imm_s;
  logic [DATA_WIDTH-1:0] imm_b;
  logic [DATA_WIDTH-1:0] imm_u;
  logic [DATA_WIDTH-1:0] imm_j;
  logic [DATA_WIDTH-1:0] imm;
  logic [4:0]            rd;
  logic                  on_path;   // Item is on the architectural path
  logic                  squash_q;  // Dropping wrong-path items after a JAL
  logic [DATA_WIDTH-1:0] target_q;  // JAL target the squash waits for

  //////////////////////////////
  // Opcode classification
  //////////////////////////////
  always_comb begin
    case (f.instr[6:0])
      OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
      OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_SYSTEM: begin
        opcode = opcode_e'(f.instr[6:0]);  // Enum values are the raw patterns
      end
      default: begin
        opcode = OPC_ILLEGAL;
      end
    endcase
  end

  // Immediates per format, all sign-extended from bit 31
  assign imm_i = {{20{f.instr[31]}}, f.instr[31:20]};
  assign imm_s = {{20{f.instr[31]}}, f.instr[31:25], f.instr[11:7]};
  assign imm_b = {{19{f.instr[31]}}, f.instr[31], f.instr[7], f.instr[30:25],
                  f.instr[11:8], 1'b0};
  assign imm_u = {f.instr[31:12], 12'b0};
  assign imm_j = {{11{f.instr[31]}}, f.instr[31], f.instr[19:12], f.instr[20],
                  f.instr[30:21], 1'b0};

  always_comb begin
    rd = f.instr[11:7];
    case (opcode)
      OPC_LUI, OPC_AUIPC:                       imm = imm_u;
      OPC_JAL:                                  imm = imm_j;
      OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_SYSTEM: imm = imm_i;
      OPC_STORE: begin
        imm = imm_s;
        rd  = 5'd0;  // Bits 11:7 carry imm[4:0]
      end
      OPC_BRANCH: begin
        imm = imm_b;
        rd  = 5'd0;
      end
      default: imm = '0;  // R-type and illegal
    endcase
  end

  //////////////////////////////
  // JAL redirect and squash
  //////////////////////////////
  // While squashing, only the stored target ends the wrong-path stream
  assign on_path = ~squash_q | (f.pc == target_q);

  assign f.ready    = d.ready;  // Back-pressure straight through to fetch
  assign f.jmp      = f.valid & on_path & f.ready & (opcode == OPC_JAL);
  assign f.jmp_addr = f.pc + imm_j;

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      squash_q <= 1'b0;
    end else if (f.valid & f.ready) begin
      if (f.jmp) begin
        squash_q <= 1'b1;
      end else if (on_path) begin
        squash_q <= 1'b0;  // Target reached
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (f.jmp) begin
      target_q <= f.jmp_addr;
    end
  end

  // Outputs to the register stage
  assign d.valid  = f.valid & on_path;
  assign d.instr  = f.instr;
  assign d.pc     = f.pc;
  assign d.opcode = opcode;
  assign d.rd     = rd;
  assign d.imm    = imm;

endmodule : instr_decode

// File: verilog/instr_fetch.sv
module instr_fetch import fetch_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  logic                  run_i,       // Low holds the pipe at its current address

  // ROM read port
  output logic [DATA_WIDTH-1:0] rom_addr_o,
  input  logic [DATA_WIDTH-1:0] rom_data_i,  // Word for last cycle's address

  fetch_if.fetch                f
);

  // pc_sr[0] is on the ROM address, pc_sr[1] matches rom_data_i, pc_sr[2] matches instr_q
  logic [DATA_WIDTH-1:0]   pc_sr [FETCH_STAGES];
  // Bit 0 tags pc_sr[1] and the top bit tags pc_sr[2]
  logic [FETCH_STAGES-2:0] valid_sr;
  logic [DATA_WIDTH-1:0]   instr_q;
  logic [DATA_WIDTH-1:0]   stall_save_q;   // ROM word caught as the pipe froze
  logic                    after_stall_q;  // Last clock edge did not advance the pipe
  logic                    advance;        // Whole pipe shifts this cycle

  assign advance = f.ready & run_i;

  //////////////////////////////
  // Program counter
  //////////////////////////////
  assign rom_addr_o = pc_sr[0];  // ROM address tracks the head of the shift register
  assign f.pc       = pc_sr[FETCH_STAGES-1];

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      for (int i = 0; i < FETCH_STAGES; i++) begin
        pc_sr[i] <= BOOT_ADDR;
      end
    end else if (advance) begin
      if (f.jmp) begin
        pc_sr[0] <= f.jmp_addr;         // Redirect to the JAL target
      end else begin
        pc_sr[0] <= pc_sr[0] + PC_STEP; // Sequential fetch
      end
      for (int i = 1; i < FETCH_STAGES; i++) begin
        pc_sr[i] <= pc_sr[i-1];
      end
    end
  end

  //////////////////////////////
  // Valid tracking
  //////////////////////////////
  // The address leaving pc_sr[0] on a jump is wrong-path and enters invalid
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      valid_sr <= '0;
    end else if (advance) begin
      valid_sr <= {valid_sr[FETCH_STAGES-3:0], ~f.jmp};
    end
  end

  // Nothing is offered to decode while the core is halted
  assign f.valid = valid_sr[FETCH_STAGES-2] & run_i;

  //////////////////////////////
  // Instruction register
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      instr_q <= NOP_INSTR;
    end else if (advance) begin
      if (after_stall_q) begin
        instr_q <= stall_save_q;  // ROM now shows the word for pc_sr[0] so the saved one goes in
      end else begin
        instr_q <= rom_data_i;
      end
    end
  end

  assign f.instr = instr_q;

  // Stall save
  // Catch rom_data_i on the first frozen edge while it still belongs to pc_sr[1]
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      stall_save_q <= NOP_INSTR;
    end else if (!after_stall_q) begin
      stall_save_q <= rom_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      after_stall_q <= 1'b0;
    end else begin
      after_stall_q <= ~advance;  // Frozen by ready or by run_i alike
    end
  end

endmodule : instr_fetch

// File: verilog/instr_rom.sv
module instr_rom import fetch_pkg::*; (
  input  logic                  clk_i,

  // Load port, written by the testbench before the core runs
  input  logic                  wr_en_i,
  input  logic [ROM_AW-1:0]     wr_addr_i,  // Word index
  input  logic [DATA_WIDTH-1:0] wr_data_i,

  // Read port, one cycle delay, no enable
  input  logic [DATA_WIDTH-1:0] rd_addr_i,  // Byte address
  output logic [DATA_WIDTH-1:0] rd_data_o
);

  logic [DATA_WIDTH-1:0] mem [ROM_DEPTH];  // Program words

  //////////////////////////////
  // Load port
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  //////////////////////////////
  // Registered read
  //////////////////////////////
  // Byte address down to a word index, upper bits wrap around the array
  always_ff @(posedge clk_i) begin
    rd_data_o <= mem[rd_addr_i[ROM_AW+1:2]];  // Data follows the address one clock later
  end

endmodule : instr_rom

// File: verilog/pipe_if.sv
// Fetch unit to decoder
interface fetch_if import fetch_pkg::*; ();
  logic [DATA_WIDTH-1:0] instr;     // Fetched instruction word
  logic [DATA_WIDTH-1:0] pc;        // Byte address of instr
  logic                  valid;     // instr/pc hold a live item
  logic                  ready;     // Level, high advances the whole fetch pipe
  logic                  jmp;       // One-cycle redirect pulse
  logic [DATA_WIDTH-1:0] jmp_addr;  // Next fetch address while jmp is high

  modport fetch  (output instr, pc, valid, input  ready, jmp, jmp_addr);
  modport decode (input  instr, pc, valid, output ready, jmp, jmp_addr);
endinterface : fetch_if

// Decoder to output register stage
interface dec_if import fetch_pkg::*; ();
  logic                  valid;
  logic [DATA_WIDTH-1:0] instr;
  logic [DATA_WIDTH-1:0] pc;
  opcode_e               opcode;  // Classified major opcode
  logic [4:0]            rd;      // Destination register, zero when the format has none
  logic [DATA_WIDTH-1:0] imm;     // Sign-extended immediate of the format
  logic                  ready;   // Output stage can take an item this cycle

  modport decode (output valid, instr, pc, opcode, rd, imm, input  ready);
  modport out    (input  valid, instr, pc, opcode, rd, imm, output ready);
endinterface : dec_if
